// File: mips_ls_core.f
src/mips_ls_pkg.sv
src/ls_req_if.sv
src/cpu_sequencer.sv
src/instr_decoder.sv
src/load_store.sv
src/register_file.sv
src/mips_ls_core.sv
verification/mips_ls_core_props.sv
verification/mips_ls_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f mips_ls_core.f --top-module mips_ls_core_tb -Mdir obj_dir

output=$(./obj_dir/Vmips_ls_core_tb)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: src/cpu_sequencer.sv
`default_nettype none

module cpu_sequencer #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   waitrequest,
    input  logic [31:0]            mem_readdata,
    input  logic                   mem_access,    // EXEC1 has a bus request out
    output mips_ls_pkg::cpu_state_e state,
    output logic [31:0]            pc,
    output logic [31:0]            instruction
);

    mips_ls_pkg::cpu_state_e state_next;
    logic [31:0]             instr_reg;

    always_comb begin
        state_next = state;
        case (state)
            mips_ls_pkg::FETCH: begin
                if (!waitrequest) begin
                    state_next = mips_ls_pkg::DECODE;   // Fetch accepted
                end
            end
            mips_ls_pkg::DECODE: begin
                state_next = mips_ls_pkg::EXEC1;
            end
            mips_ls_pkg::EXEC1: begin
                // Only a real access can be stalled
                if (!(mem_access && waitrequest)) begin
                    state_next = mips_ls_pkg::EXEC2;
                end
            end
            default: begin
                state_next = mips_ls_pkg::FETCH;        // EXEC2
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_ls_pkg::FETCH;
            pc    <= RESET_VECTOR;
        end else begin
            state <= state_next;
            if (state == mips_ls_pkg::EXEC2) begin
                pc <= pc + 32'd4;                        // Same edge as the register write
            end
        end
    end

    // Fetched word arrives during DECODE
    always_ff @(posedge clk) begin
        if (state == mips_ls_pkg::DECODE) begin
            instr_reg <= mem_readdata;
        end
    end

    // Bypass so the fields are already valid in DECODE
    assign instruction = (state == mips_ls_pkg::DECODE) ? mem_readdata : instr_reg;

endmodule

`default_nettype wire

// File: src/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input  logic [31:0] instruction,
    ls_req_if.source    req
);

    logic [5:0] opcode;

    assign opcode = instruction[31:26];

    // I-type fields
    assign req.rs     = instruction[25:21];
    assign req.rt     = instruction[20:16];
    assign req.offset = instruction[15:0];

    always_comb begin
        case (opcode)
            mips_ls_pkg::OP_LB: begin
                req.op = mips_ls_pkg::LS_LB;
            end
            mips_ls_pkg::OP_LBU: begin
                req.op = mips_ls_pkg::LS_LBU;
            end
            mips_ls_pkg::OP_LH: begin
                req.op = mips_ls_pkg::LS_LH;
            end
            mips_ls_pkg::OP_LHU: begin
                req.op = mips_ls_pkg::LS_LHU;
            end
            mips_ls_pkg::OP_LUI: begin
                req.op = mips_ls_pkg::LS_LUI;
            end
            mips_ls_pkg::OP_LW: begin
                req.op = mips_ls_pkg::LS_LW;
            end
            mips_ls_pkg::OP_LWL: begin
                req.op = mips_ls_pkg::LS_LWL;
            end
            mips_ls_pkg::OP_LWR: begin
                req.op = mips_ls_pkg::LS_LWR;
            end
            mips_ls_pkg::OP_SB: begin
                req.op = mips_ls_pkg::LS_SB;
            end
            mips_ls_pkg::OP_SH: begin
                req.op = mips_ls_pkg::LS_SH;
            end
            mips_ls_pkg::OP_SW: begin
                req.op = mips_ls_pkg::LS_SW;
            end
            default: begin
                // Unsupported opcode just advances the PC
                req.op = mips_ls_pkg::LS_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/load_store.sv
`default_nettype none

module load_store (
    input  logic                    clk,
    input  mips_ls_pkg::cpu_state_e state,
    input  logic [31:0]             pc,
    ls_req_if.sink                  req,

    input  logic [31:0]             rs_data,
    input  logic [31:0]             rt_data,
    output logic                    reg_writeenable,
    output logic [4:0]              reg_address,
    output logic [31:0]             reg_writedata,

    output logic                    mem_access,

    input  logic [31:0]             mem_readdata,
    output logic [31:0]             mem_address,
    output logic [3:0]              mem_byteenable,
    output logic [31:0]             mem_writedata,
    output logic                    mem_writeenable,
    output logic                    mem_readenable
);

    logic [31:0]           offset_ext;
    logic [31:0]           eff_addr;
    logic [1:0]            lane_q;       // Byte offset kept for EXEC2
    logic [4:0]            lane_shift;
    logic                  is_load;
    logic                  is_store;
    logic                  in_exec1;
    mips_ls_pkg::mem_word_u load_word;
    mips_ls_pkg::mem_word_u store_word;
    logic [7:0]            byte_sel;
    logic [15:0]           half_sel;
    logic [31:0]           lwl_data;
    logic [31:0]           lwr_data;

    assign offset_ext = {{16{req.offset[15]}}, req.offset};
    assign eff_addr   = rs_data + offset_ext;

    assign is_load = (req.op == mips_ls_pkg::LS_LB)  || (req.op == mips_ls_pkg::LS_LBU) ||
                     (req.op == mips_ls_pkg::LS_LH)  || (req.op == mips_ls_pkg::LS_LHU) ||
                     (req.op == mips_ls_pkg::LS_LW)  || (req.op == mips_ls_pkg::LS_LWL) ||
                     (req.op == mips_ls_pkg::LS_LWR);
    assign is_store = (req.op == mips_ls_pkg::LS_SB) || (req.op == mips_ls_pkg::LS_SH) ||
                      (req.op == mips_ls_pkg::LS_SW);

    assign in_exec1        = (state == mips_ls_pkg::EXEC1);
    assign mem_access      = in_exec1 && (is_load || is_store);
    assign mem_readenable  = (state == mips_ls_pkg::FETCH) || (in_exec1 && is_load);
    assign mem_writeenable = in_exec1 && is_store;
    assign mem_address     = (state == mips_ls_pkg::FETCH) ? pc : {eff_addr[31:2], 2'b00};

    always_comb begin
        mem_byteenable = 4'b1111;                // Fetch and word accesses
        if (in_exec1) begin
            case (req.op)
                mips_ls_pkg::LS_LB, mips_ls_pkg::LS_LBU, mips_ls_pkg::LS_SB: begin
                    mem_byteenable = 4'b0001 << eff_addr[1:0];
                end
                mips_ls_pkg::LS_LH, mips_ls_pkg::LS_LHU, mips_ls_pkg::LS_SH: begin
                    mem_byteenable = eff_addr[1] ? 4'b1100 : 4'b0011;
                end
                mips_ls_pkg::LS_LWL: begin
                    mem_byteenable = 4'b1111 >> eff_addr[1:0];   // 4-k low lanes
                end
                mips_ls_pkg::LS_LWR: begin
                    mem_byteenable = 4'b1111 << eff_addr[1:0];   // Lanes k to 3
                end
                default: begin
                    mem_byteenable = 4'b1111;
                end
            endcase
        end
    end

    // Store data copied into every lane
    always_comb begin
        store_word.word = rt_data;
        case (req.op)
            mips_ls_pkg::LS_SB: begin
                store_word.lanes = {4{rt_data[7:0]}};
            end
            mips_ls_pkg::LS_SH: begin
                store_word.halves = {2{rt_data[15:0]}};
            end
            default: begin
                store_word.word = rt_data;
            end
        endcase
    end

    assign mem_writedata = store_word.word;

    always_ff @(posedge clk) begin
        if (in_exec1) begin
            lane_q <= eff_addr[1:0];
        end
    end

    // Load extraction, data valid in EXEC2
    assign load_word.word = mem_readdata;
    assign byte_sel       = load_word.lanes[lane_q];
    assign half_sel       = load_word.halves[lane_q[1]];
    assign lane_shift     = {lane_q, 3'b000};

    // Memory bytes over the kept low register bytes
    assign lwl_data = (mem_readdata << lane_shift) | (rt_data & ~(32'hffff_ffff << lane_shift));
    // Kept high register bytes over the shifted memory word
    assign lwr_data = (mem_readdata >> lane_shift) | (rt_data & ~(32'hffff_ffff >> lane_shift));

    always_comb begin
        case (req.op)
            mips_ls_pkg::LS_LB: begin
                reg_writedata = {{24{byte_sel[7]}}, byte_sel};
            end
            mips_ls_pkg::LS_LBU: begin
                reg_writedata = {24'h000000, byte_sel};
            end
            mips_ls_pkg::LS_LH: begin
                reg_writedata = {{16{half_sel[15]}}, half_sel};
            end
            mips_ls_pkg::LS_LHU: begin
                reg_writedata = {16'h0000, half_sel};
            end
            mips_ls_pkg::LS_LUI: begin
                reg_writedata = {req.offset, 16'h0000};
            end
            mips_ls_pkg::LS_LWL: begin
                reg_writedata = lwl_data;
            end
            mips_ls_pkg::LS_LWR: begin
                reg_writedata = lwr_data;
            end
            default: begin
                reg_writedata = mem_readdata;   // lw, others never write
            end
        endcase
    end

    assign reg_address     = req.rt;
    assign reg_writeenable = (state == mips_ls_pkg::EXEC2) &&
                             (is_load || (req.op == mips_ls_pkg::LS_LUI)) &&
                             (req.rt != 5'd0);     // $zero stays zero

endmodule

`default_nettype wire

// File: src/ls_req_if.sv
`default_nettype none

// Decoded load/store request, held stable by the instruction register
interface ls_req_if;

    mips_ls_pkg::ls_op_e op;
    logic [15:0]         offset;   // Raw immediate
    logic [4:0]          rs;       // Base register
    logic [4:0]          rt;       // Data register

    modport source (
        output op, offset, rs, rt
    );

    modport sink (
        input op, offset, rs, rt
    );

endinterface

`default_nettype wire

// File: src/mips_ls_core.sv
`default_nettype none

module mips_ls_core #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] mem_readdata,
    input  logic        waitrequest,
    output logic [31:0] mem_address,
    output logic [3:0]  mem_byteenable,
    output logic [31:0] mem_writedata,
    output logic        mem_writeenable,
    output logic        mem_readenable
);

    mips_ls_pkg::cpu_state_e state;
    logic [31:0]             pc;
    logic [31:0]             instruction;
    logic                    mem_access;
    logic                    reg_writeenable;
    logic [4:0]              reg_address;
    logic [31:0]             reg_writedata;
    logic [31:0]             rs_data;
    logic [31:0]             rt_data;

    ls_req_if req ();

    cpu_sequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_cpu_sequencer (
        .clk          (clk),
        .reset        (reset),
        .waitrequest  (waitrequest),
        .mem_readdata (mem_readdata),
        .mem_access   (mem_access),
        .state        (state),
        .pc           (pc),
        .instruction  (instruction)
    );

    instr_decoder u_instr_decoder (
        .instruction (instruction),
        .req         (req)
    );

    load_store u_load_store (
        .clk             (clk),
        .state           (state),
        .pc              (pc),
        .req             (req),
        .rs_data         (rs_data),
        .rt_data         (rt_data),
        .reg_writeenable (reg_writeenable),
        .reg_address     (reg_address),
        .reg_writedata   (reg_writedata),
        .mem_access      (mem_access),
        .mem_readdata    (mem_readdata),
        .mem_address     (mem_address),
        .mem_byteenable  (mem_byteenable),
        .mem_writedata   (mem_writedata),
        .mem_writeenable (mem_writeenable),
        .mem_readenable  (mem_readenable)
    );

    register_file u_register_file (
        .clk         (clk),
        .reset       (reset),
        .rs_addr     (req.rs),
        .rt_addr     (req.rt),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .writeenable (reg_writeenable),
        .address     (reg_address),
        .writedata   (reg_writedata)
    );

endmodule

`default_nettype wire

// File: src/mips_ls_pkg.sv
`default_nettype none

package mips_ls_pkg;

    // Main sequence is FETCH, DECODE, EXEC1, EXEC2
    typedef enum logic [1:0] {
        FETCH  = 2'b00,
        EXEC1  = 2'b01,
        EXEC2  = 2'b10,
        DECODE = 2'b11
    } cpu_state_e;

    typedef enum logic [3:0] {
        LS_NONE = 4'd0,   // Anything outside the load/store set
        LS_LB   = 4'd1,
        LS_LBU  = 4'd2,
        LS_LH   = 4'd3,
        LS_LHU  = 4'd4,
        LS_LUI  = 4'd5,   // No bus access
        LS_LW   = 4'd6,
        LS_LWL  = 4'd7,
        LS_LWR  = 4'd8,
        LS_SB   = 4'd9,
        LS_SH   = 4'd10,
        LS_SW   = 4'd11
    } ls_op_e;

    // One bus word seen as bytes or as halfwords
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  lanes;    // Lane n is bits 8n+7 to 8n
        logic [1:0][15:0] halves;   // Picked by address bit 1
    } mem_word_u;

    // Standard MIPS primary opcodes
    localparam logic [5:0] OP_LUI = 6'h0f;
    localparam logic [5:0] OP_LB  = 6'h20;
    localparam logic [5:0] OP_LH  = 6'h21;
    localparam logic [5:0] OP_LWL = 6'h22;
    localparam logic [5:0] OP_LW  = 6'h23;
    localparam logic [5:0] OP_LBU = 6'h24;
    localparam logic [5:0] OP_LHU = 6'h25;
    localparam logic [5:0] OP_LWR = 6'h26;
    localparam logic [5:0] OP_SB  = 6'h28;
    localparam logic [5:0] OP_SH  = 6'h29;
    localparam logic [5:0] OP_SW  = 6'h2b;

endpackage

`default_nettype wire

// File: src/register_file.sv
`default_nettype none

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        writeenable,
    input  logic [4:0]  address,
    input  logic [31:0] writedata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (writeenable && (address != 5'd0)) begin
            regs[address] <= writedata;
        end
    end

    // Asynchronous reads, register 0 hardwired
    assign rs_data = (rs_addr == 5'd0) ? 32'h0000_0000 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'h0000_0000 : regs[rt_addr];

endmodule

`default_nettype wire

// File: verification/mips_ls_core_props.sv
`default_nettype none

module mips_ls_core_props (
    input wire logic                    clk,
    input wire mips_ls_pkg::cpu_state_e state,
    input wire logic                    mem_access,
    input wire logic [31:0]             mem_address,
    input wire logic [3:0]              mem_byteenable,
    input wire logic [31:0]             mem_writedata,
    input wire logic                    mem_writeenable,
    input wire logic                    mem_readenable
);

    int error_count = 0;   // Failed assertions so far

    a_no_read_and_write: assert property (@(posedge clk) !(mem_readenable && mem_writeenable))
        else begin
            error_count++;
            $error("read and write enables high together");
        end

    a_data_word_aligned: assert property (@(posedge clk)
        (state != mips_ls_pkg::FETCH) |-> (mem_address[1:0] == 2'b00))
        else begin
            error_count++;
            $error("data address not word aligned");
        end

    // A data access still in EXEC1 one cycle later was stalled
    a_stall_stable: assert property (@(posedge clk)
        ((state == mips_ls_pkg::EXEC1) && $past((state == mips_ls_pkg::EXEC1) && mem_access))
        |-> ($stable(mem_address) && $stable(mem_byteenable) && $stable(mem_writedata)
             && $stable(mem_readenable) && $stable(mem_writeenable)))
        else begin
            error_count++;
            $error("bus outputs changed during a stall");
        end

    a_enables_present: assert property (@(posedge clk) mem_access |-> (mem_byteenable != 4'b0000))
        else begin
            error_count++;
            $error("data access with no byte enabled");
        end

endmodule

bind load_store mips_ls_core_props u_props (
    .clk             (clk),
    .state           (state),
    .mem_access      (mem_access),
    .mem_address     (mem_address),
    .mem_byteenable  (mem_byteenable),
    .mem_writedata   (mem_writedata),
    .mem_writeenable (mem_writeenable),
    .mem_readenable  (mem_readenable)
);

`default_nettype wire

// File: verification/mips_ls_core_tb.sv
`default_nettype none

module mips_ls_core_tb;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic [31:0] mem_readdata;
    wire  [31:0] mem_address;
    wire  [3:0]  mem_byteenable;
    wire  [31:0] mem_writedata;
    wire         mem_writeenable;
    wire         mem_readenable;

    logic [31:0] mem [256];       // 1 KB, aliased over the address space
    logic [31:0] prog [$];
    logic [31:0] rd_addr [$];
    logic [31:0] wr_addr [$];
    logic [31:0] wr_data [$];
    logic [3:0]  wr_be [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_be [$];
    int          stall_run;
    int          cycle_count;
    int          cycle_limit;
    logic        running;
    logic        log_reads;

    mips_ls_core u_mips_ls_core (
        .clk (clk), .reset (reset), .mem_readdata (mem_readdata), .waitrequest (waitrequest),
        .mem_address (mem_address), .mem_byteenable (mem_byteenable),
        .mem_writedata (mem_writedata), .mem_writeenable (mem_writeenable),
        .mem_readenable (mem_readenable)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin : memory_model
        mips_ls_pkg::mem_word_u cur;
        mips_ls_pkg::mem_word_u wd;
        if (mem_readenable && !waitrequest) begin
            mem_readdata <= mem[mem_address[9:2]];      // Valid next cycle
            if (!reset && log_reads) rd_addr.push_back(mem_address);
        end
        if (mem_writeenable && !waitrequest) begin
            cur.word = mem[mem_address[9:2]];
            wd.word  = mem_writedata;
            for (int j = 0; j < 4; j++) begin
                if (mem_byteenable[j]) cur.lanes[j] = wd.lanes[j];
            end
            mem[mem_address[9:2]] = cur.word;
            if (!reset) begin
                wr_addr.push_back(mem_address);
                wr_be.push_back(mem_byteenable);
                wr_data.push_back(mem_writedata);
            end
        end
        if (stall_run >= 7 || ($urandom % 4) != 0) begin   // Stalls capped at 7 cycles
            waitrequest <= 1'b0;
            stall_run   <= 0;
        end else begin
            waitrequest <= 1'b1;
            stall_run   <= stall_run + 1;
        end
    end

    always @(posedge clk) begin : watchdog
        if (!running) begin
            cycle_count <= 0;
        end else if (cycle_count > cycle_limit) begin
            $display("ERROR: program did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $fatal(1);
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    function automatic logic [31:0] itype(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] fill_word(int i);
        return (i * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
    endfunction

    task automatic check_word(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %08h actual %08h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_byteenable(string name, logic [3:0] expected, logic [3:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_address(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %08h actual %08h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_enable(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Hold reset and load the program over the fill pattern
    task automatic begin_program();
        @(posedge clk);
        reset <= 1'b1;
        running = 1'b0;
        for (int i = 0; i < 256; i++) mem[i] = (i < prog.size()) ? prog[i] : fill_word(i);
    endtask

    task automatic run_program(int n_stores);
        repeat (9) @(posedge clk);
        @(negedge clk);
        // In reset the first fetch is already on the bus
        check_address("mem_address in reset", 32'h0, mem_address);
        check_enable("mem_readenable in reset", 1'b1, mem_readenable);
        check_enable("mem_writeenable in reset", 1'b0, mem_writeenable);
        rd_addr.delete();
        wr_addr.delete();
        wr_be.delete();
        wr_data.delete();
        cycle_limit = prog.size() * 4 * 8 + 40;
        running     = 1'b1;
        @(posedge clk);
        reset <= 1'b0;
        do @(negedge clk); while (wr_addr.size() < n_stores);
        running = 1'b0;
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_address($sformatf("mem_address[store %0d]", i), exp_addr[i], wr_addr[i]);
            check_byteenable($sformatf("mem_byteenable[store %0d]", i), exp_be[i], wr_be[i]);
            check_word($sformatf("mem_writedata[store %0d]", i), exp_data[i], wr_data[i]);
        end
        prog.delete();
        exp_addr.delete();
        exp_be.delete();
        exp_data.delete();
    endtask

    task automatic expect_store(logic [31:0] addr, logic [3:0] be, logic [31:0] data);
        exp_addr.push_back(addr);
        exp_be.push_back(be);
        exp_data.push_back(data);
    endtask

    task automatic test_fetch_sequence();
        prog = '{32'h0, 32'h0, 32'h0, 32'h0, itype(mips_ls_pkg::OP_LUI, 0, 1, 16'h1234),
                 itype(mips_ls_pkg::OP_SW, 0, 1, 16'h0100)};
        begin_program();
        expect_store(32'h100, 4'hf, 32'h1234_0000);
        log_reads = 1'b1;
        run_program(1);
        log_reads = 1'b0;
        if (rd_addr.size() < 6) begin
            $display("ERROR: only %0d fetches were seen", rd_addr.size());
            $display("test failed");
            $fatal(1);
        end
        for (int i = 0; i < 6; i++) check_address("fetch mem_address", i * 4, rd_addr[i]);
    endtask

    task automatic test_word_round_trip();
        prog = '{itype(mips_ls_pkg::OP_LUI, 0, 1, 16'h0001),
                 itype(mips_ls_pkg::OP_LW, 1, 2, 16'h0200), itype(mips_ls_pkg::OP_LW, 1, 3, 16'hfffc),
                 itype(mips_ls_pkg::OP_SW, 0, 2, 16'h0300), itype(mips_ls_pkg::OP_SW, 1, 3, 16'hfff8),
                 itype(mips_ls_pkg::OP_SW, 0, 3, 16'h0304)};
        begin_program();
        mem[8'h80] = 32'h5e1f_a0c7;
        mem[8'hff] = 32'h8b36_d214;
        expect_store(32'h0000_0300, 4'hf, 32'h5e1f_a0c7);
        expect_store(32'h0000_fff8, 4'hf, 32'h8b36_d214);
        expect_store(32'h0000_0304, 4'hf, 32'h8b36_d214);
        run_program(3);
    endtask

    task automatic test_byte_loads();
        logic [7:0] b;
        for (int k = 0; k < 4; k++) begin
            prog.push_back(itype(mips_ls_pkg::OP_LB, 0, 2, 16'h0200 + k));
            prog.push_back(itype(mips_ls_pkg::OP_LBU, 0, 3, 16'h0200 + k));
            prog.push_back(itype(mips_ls_pkg::OP_SW, 0, 2, 16'h0300 + 8 * k));
            prog.push_back(itype(mips_ls_pkg::OP_SW, 0, 3, 16'h0304 + 8 * k));
            b = 32'h8a7f_c301 >> (8 * k);
            expect_store(32'h300 + 8 * k, 4'hf, {{24{b[7]}}, b});
            expect_store(32'h304 + 8 * k, 4'hf, {24'h0, b});
        end
        begin_program();
        mem[8'h80] = 32'h8a7f_c301;
        run_program(8);
    endtask

    task automatic test_half_loads();
        logic [15:0] h;
        for (int k = 0; k < 2; k++) begin
            prog.push_back(itype(mips_ls_pkg::OP_LH, 0, 2, 16'h0204 + 2 * k));
            prog.push_back(itype(mips_ls_pkg::OP_LHU, 0, 3, 16'h0204 + 2 * k));
            prog.push_back(itype(mips_ls_pkg::OP_SW, 0, 2, 16'h0340 + 8 * k));
            prog.push_back(itype(mips_ls_pkg::OP_SW, 0, 3, 16'h0344 + 8 * k));
            h = 32'h1234_8765 >> (16 * k);
            expect_store(32'h340 + 8 * k, 4'hf, {{16{h[15]}}, h});
            expect_store(32'h344 + 8 * k, 4'hf, {16'h0, h});
        end
        begin_program();
        mem[8'h81] = 32'h1234_8765;
        run_program(4);
    endtask

    // Byte-wise merge of register and memory for lwl and lwr
    task automatic test_unaligned_loads();
        mips_ls_pkg::mem_word_u r;
        mips_ls_pkg::mem_word_u m;
        mips_ls_pkg::mem_word_u left;
        mips_ls_pkg::mem_word_u right;
        r.word = 32'ha1b2_c3d4;
        m.word = 32'h1122_3344;
        for (int k = 0; k < 4; k++) begin
            prog.push_back(itype(mips_ls_pkg::OP_LW, 0, 2, 16'h0200));
            prog.push_back(itype(mips_ls_pkg::OP_LWL, 0, 2, 16'h0204 + k));
            prog.push_back(itype(mips_ls_pkg::OP_SW, 0, 2, 16'h0360 + 8 * k));
            prog.push_back(itype(mips_ls_pkg::OP_LW, 0, 3, 16'h0200));
            prog.push_back(itype(mips_ls_pkg::OP_LWR, 0, 3, 16'h0204 + k));
            prog.push_back(itype(mips_ls_pkg::OP_SW, 0, 3, 16'h0364 + 8 * k));
            for (int j = 0; j < 4; j++) begin
                left.lanes[j]  = (j >= k) ? m.lanes[j - k] : r.lanes[j];
                right.lanes[j] = (j < 4 - k) ? m.lanes[j + k] : r.lanes[j];
            end
            expect_store(32'h360 + 8 * k, 4'hf, left.word);
            expect_store(32'h364 + 8 * k, 4'hf, right.word);
        end
        begin_program();
        mem[8'h80] = r.word;
        mem[8'h81] = m.word;
        run_program(8);
    endtask

    task automatic test_partial_stores();
        mips_ls_pkg::mem_word_u w;
        prog.push_back(itype(mips_ls_pkg::OP_LW, 0, 2, 16'h0200));
        for (int k = 0; k < 4; k++) begin
            prog.push_back(itype(mips_ls_pkg::OP_SB, 0, 2, 16'h0380 + 5 * k));
            expect_store(32'h380 + 4 * k, 4'b0001 << k, 32'hd4d4_d4d4);
        end
        for (int k = 0; k < 2; k++) begin
            prog.push_back(itype(mips_ls_pkg::OP_SH, 0, 2, 16'h03a0 + 6 * k));
            expect_store(32'h3a0 + 4 * k, k ? 4'b1100 : 4'b0011, 32'hc3d4_c3d4);
        end
        begin_program();
        mem[8'h80] = 32'ha1b2_c3d4;
        run_program(6);
        for (int k = 0; k < 4; k++) begin
            w.word     = fill_word(8'he0 + k);
            w.lanes[k] = 8'hd4;
            check_word("mem after sb", w.word, mem[8'he0 + k]);
        end
        for (int k = 0; k < 2; k++) begin
            w.word      = fill_word(8'he8 + k);
            w.halves[k] = 16'hc3d4;
            check_word("mem after sh", w.word, mem[8'he8 + k]);
        end
    endtask

    initial begin
        void'($urandom(32'h50a99789));
        reset        = 1'b1;
        waitrequest  = 1'b0;
        mem_readdata = 32'h0;
        stall_run    = 0;
        running      = 1'b0;
        log_reads    = 1'b0;
        cycle_limit  = 0;
        test_fetch_sequence();
        test_word_round_trip();
        test_byte_loads();
        test_half_loads();
        test_unaligned_loads();
        test_partial_stores();
        if (u_mips_ls_core.u_load_store.u_props.error_count != 0) begin
            $display("ERROR: %0d bus assertions failed",
                     u_mips_ls_core.u_load_store.u_props.error_count);
            $display("test failed");
            $fatal(1);
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
